// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_lcd_ctrl
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
source/lcd_pkg.sv
source/axil_lcd_regs.sv
source/lcd_cmd_fifo.sv
source/lcd_bus_writer.sv
source/lcd_ctrl_top.sv
test/tb_clock.sv
test/tb_lcd_ctrl.sv

// File: source/axil_lcd_regs.sv
`timescale 1ns/1ps

module axil_lcd_regs
  import lcd_pkg::*;
(
  input  logic       hwclk,
  input  logic       reset,
  // write address / data / response
  input  logic       awvalid,
  output logic       awready,
  input  axil_addr_t awaddr,
  input  logic       wvalid,
  output logic       wready,
  input  axil_data_t wdata,
  output logic       bvalid,
  input  logic       bready,
  output axil_resp_t bresp,
  // read address / data
  input  logic       arvalid,
  output logic       arready,
  input  axil_addr_t araddr,
  output logic       rvalid,
  input  logic       rready,
  output axil_data_t rdata,
  output axil_resp_t rresp,
  // queue side
  output logic       push,
  output lcd_item_t  push_item,
  input  logic       full,
  input  logic       empty,
  input  fifo_lvl_t  level,
  // bus writer side
  input  logic       active,
  output wr_width_t  wr_width
);

  logic       aw_is_cmd;
  logic       aw_is_data;
  logic       aw_is_timing;
  logic       aw_is_queue;
  logic       wr_hs;
  logic       rd_hs;
  logic       busy;
  axil_data_t status_word;

  // decode straight off awaddr, master holds it until the handshake
  assign aw_is_cmd    = (awaddr == REG_CMD);
  assign aw_is_data   = (awaddr == REG_DATA);
  assign aw_is_timing = (awaddr == REG_TIMING);
  assign aw_is_queue  = aw_is_cmd || aw_is_data;

  // address and data accepted in the same cycle
  assign wready = awready;
  assign wr_hs  = awvalid && awready && wvalid && wready;

  // one queue push per accepted cmd/data write
  assign push      = wr_hs && aw_is_queue;
  assign push_item = {aw_is_data, wdata[7:0]};

  // single outstanding read
  assign arready = !rvalid;
  assign rd_hs   = arvalid && arready;

  // anything queued or still on the panel bus
  assign busy = !empty || active;

  // full bit0, empty bit1, busy bit2, level 11:8
  assign status_word = {{(AXIL_DATA_W-12){1'b0}}, level, 5'b0_0000, busy, empty, full};

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      awready  <= 1'b0;
      bvalid   <= 1'b0;
      wr_width <= WR_CYCLES_RST;
    end else begin
      // one-cycle ready pulse, no response pending
      // full queue stalls only cmd/data writes
      awready <= awvalid && wvalid && !awready && !bvalid && (!full || !aw_is_queue);

      if (wr_hs) begin
        bvalid <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end

      // zero width would never strobe, clamp to 1
      if (wr_hs && aw_is_timing) begin
        if (wdata[3:0] == 4'd0) begin
          wr_width <= wr_width_t'(1);
        end else begin
          wr_width <= wdata[3:0];
        end
      end
    end
  end

  // write response code
  // status is read only, so a write there is an error too
  always_ff @(posedge hwclk) begin
    if (wr_hs) begin
      if (aw_is_queue || aw_is_timing) begin
        bresp <= RESP_OKAY;
      end else begin
        bresp <= RESP_SLVERR;
      end
    end
  end

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (rd_hs) begin
      rvalid <= 1'b1;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
    end
  end

  // read data captured at address accept
  always_ff @(posedge hwclk) begin
    if (rd_hs) begin
      case (araddr)
        REG_STATUS: begin
          rdata <= status_word;
          rresp <= RESP_OKAY;
        end
        REG_TIMING: begin
          rdata <= axil_data_t'(wr_width);
          rresp <= RESP_OKAY;
        end
        // cmd/data are write only, rest unmapped
        default: begin
          rdata <= '0;
          rresp <= RESP_SLVERR;
        end
      endcase
    end
  end

  // responses held until taken
  a_bvalid_hold: assert property (@(posedge hwclk) disable iff (reset)
    bvalid && !bready |=> bvalid);
  a_rvalid_hold: assert property (@(posedge hwclk) disable iff (reset)
    rvalid && !rready |=> rvalid);

endmodule

// File: source/lcd_bus_writer.sv
`timescale 1ns/1ps

module lcd_bus_writer
  import lcd_pkg::*;
(
  input  logic      hwclk,
  input  logic      reset,
  input  logic      empty,
  input  lcd_item_t pop_item,
  output logic      pop,
  input  wr_width_t wr_width,
  output logic      active,
  output lcd_byte_t lcd_data,
  output logic      wrx,
  output logic      csx,
  output logic      dcx
);

  bus_state_t state;
  bus_state_t state_n;
  // counts 1..width_q within a strobe phase
  wr_width_t  cnt;
  wr_width_t  cnt_n;
  // width latched per item
  wr_width_t  width_q;
  lcd_item_t  item_q;
  logic       phase_done;

  assign phase_done = (cnt == width_q);

  always_comb begin
    state_n = state;
    cnt_n   = cnt;
    pop     = 1'b0;
    case (state)
      IDLE: begin
        if (!empty) begin
          pop     = 1'b1;
          state_n = LOAD;
        end
      end
      // setup cycle, cs low and data/dc driven
      LOAD: begin
        state_n = STROBE_LO;
        cnt_n   = wr_width_t'(1);
      end
      STROBE_LO: begin
        if (phase_done) begin
          state_n = STROBE_HI;
          cnt_n   = wr_width_t'(1);
        end else begin
          cnt_n = cnt + 1'b1;
        end
      end
      STROBE_HI: begin
        if (phase_done) begin
          // back to back items keep cs low
          if (!empty) begin
            pop     = 1'b1;
            state_n = LOAD;
          end else begin
            state_n = IDLE;
          end
        end else begin
          cnt_n = cnt + 1'b1;
        end
      end
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      state <= state_n;
      cnt   <= cnt_n;
    end
  end

  // item taken with the pop, width sampled in LOAD
  always_ff @(posedge hwclk) begin
    if (pop) begin
      item_q <= pop_item;
    end
    if (state == LOAD) begin
      width_q <= wr_width;
    end
  end

  // panel pins, strobe low only in STROBE_LO
  assign lcd_data = item_q[7:0];
  assign dcx      = item_q[8];
  assign wrx      = (state != STROBE_LO);
  assign csx      = (state == IDLE);
  assign active   = (state != IDLE);

  // panel latches on wrx rise, bus must hold through it
  a_bus_stable: assert property (@(posedge hwclk) disable iff (reset)
    !wrx |=> $stable(lcd_data) && $stable(dcx));

endmodule

// File: source/lcd_cmd_fifo.sv
`timescale 1ns/1ps

module lcd_cmd_fifo
  import lcd_pkg::*;
(
  input  logic      hwclk,
  input  logic      reset,
  input  logic      push,
  input  lcd_item_t push_item,
  input  logic      pop,
  output lcd_item_t pop_item,
  output logic      full,
  output logic      empty,
  output fifo_lvl_t level
);

  // storage, no reset needed
  lcd_item_t mem [FIFO_DEPTH];

  // depth is a power of two, pointers wrap on their own
  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;

  assign full  = (level == fifo_lvl_t'(FIFO_DEPTH));
  assign empty = (level == '0);

  // head visible without popping
  assign pop_item = mem[rd_ptr];

  always_ff @(posedge hwclk) begin
    if (push) begin
      mem[wr_ptr] <= push_item;
    end
  end

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves level alone
      case ({push, pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  // both neighbours must respect the flags
  a_no_overflow:  assert property (@(posedge hwclk) disable iff (reset) push |-> !full);
  a_no_underflow: assert property (@(posedge hwclk) disable iff (reset) pop |-> !empty);

endmodule

// File: source/lcd_ctrl_top.sv
`timescale 1ns/1ps

module lcd_ctrl_top
  import lcd_pkg::*;
(
  input  logic       hwclk,
  input  logic       reset,
  input  logic       awvalid,
  output logic       awready,
  input  axil_addr_t awaddr,
  input  logic       wvalid,
  output logic       wready,
  input  axil_data_t wdata,
  output logic       bvalid,
  input  logic       bready,
  output axil_resp_t bresp,
  input  logic       arvalid,
  output logic       arready,
  input  axil_addr_t araddr,
  output logic       rvalid,
  input  logic       rready,
  output axil_data_t rdata,
  output axil_resp_t rresp,
  // 8080 panel pins, rdx tied off outside
  output lcd_byte_t  lcd_data,
  output logic       wrx,
  output logic       csx,
  output logic       dcx
);

  // regs to queue
  logic      push;
  lcd_item_t push_item;
  logic      full;
  logic      empty;
  fifo_lvl_t level;
  // queue to bus writer
  logic      pop;
  lcd_item_t pop_item;
  // bus writer status and config
  logic      active;
  wr_width_t wr_width;

  axil_lcd_regs u_regs (
    .hwclk, .reset,
    .awvalid, .awready, .awaddr,
    .wvalid, .wready, .wdata,
    .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr,
    .rvalid, .rready, .rdata, .rresp,
    .push, .push_item,
    .full, .empty, .level,
    .active, .wr_width
  );

  lcd_cmd_fifo u_fifo (
    .hwclk, .reset,
    .push, .push_item,
    .pop, .pop_item,
    .full, .empty, .level
  );

  lcd_bus_writer u_writer (
    .hwclk, .reset,
    .empty, .pop_item, .pop,
    .wr_width, .active,
    .lcd_data, .wrx, .csx, .dcx
  );

endmodule

// File: source/lcd_pkg.sv
package lcd_pkg;

  // axi4-lite port geometry
  localparam int AXIL_ADDR_W = 4;
  localparam int AXIL_DATA_W = 32;

  // command queue geometry
  localparam int FIFO_DEPTH = 8;
  // counts 0..FIFO_DEPTH inclusive
  localparam int FIFO_LVL_W = 4;

  typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [1:0]             axil_resp_t;

  // panel byte and queue entry
  typedef logic [7:0] lcd_byte_t;
  // bit 8 set means data, clear means command
  typedef logic [8:0] lcd_item_t;

  // strobe phase length in hwclk cycles
  typedef logic [3:0]            wr_width_t;
  typedef logic [FIFO_LVL_W-1:0] fifo_lvl_t;

  // register map offsets
  localparam axil_addr_t REG_CMD    = 4'h0;
  localparam axil_addr_t REG_DATA   = 4'h4;
  localparam axil_addr_t REG_STATUS = 4'h8;
  localparam axil_addr_t REG_TIMING = 4'hC;

  localparam wr_width_t WR_CYCLES_RST = 4'd2;

  // axi response codes
  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // 8080 write sequencer states
  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    STROBE_LO,
    STROBE_HI
  } bus_state_t;

endpackage

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic hwclk,
  output logic reset
);

  // 10 ns period
  initial begin
    hwclk = 1'b0;
    forever #5 hwclk = ~hwclk;
  end

  // held over the first 5 rising edges
  initial begin
    reset = 1'b1;
    repeat (5) @(posedge hwclk);
    #1;
    reset = 1'b0;
  end

endmodule

// File: test/tb_lcd_ctrl.sv
`timescale 1ns/1ps

module tb_lcd_ctrl
  import lcd_pkg::*;
();

  localparam time CLK_PERIOD     = 10;
  localparam int  TIMEOUT_CYCLES = 2000;

  logic       hwclk;
  logic       reset;
  logic       awvalid;
  logic       awready;
  axil_addr_t awaddr;
  logic       wvalid;
  logic       wready;
  axil_data_t wdata;
  logic       bvalid;
  logic       bready;
  axil_resp_t bresp;
  logic       arvalid;
  logic       arready;
  axil_addr_t araddr;
  logic       rvalid;
  logic       rready;
  axil_data_t rdata;
  axil_resp_t rresp;
  lcd_byte_t  lcd_data;
  logic       wrx;
  logic       csx;
  logic       dcx;

  // bus log and the items the host queued
  lcd_item_t seen_q [$];
  lcd_item_t exp_q [$];
  time       fall_time = 0;
  int        low_cycles = 0;
  logic      saw_full = 1'b0;

  tb_clock u_clock (
    .hwclk,
    .reset
  );

  lcd_ctrl_top DUT (
    .hwclk, .reset,
    .awvalid, .awready, .awaddr,
    .wvalid, .wready, .wdata,
    .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr,
    .rvalid, .rready, .rdata, .rresp,
    .lcd_data, .wrx, .csx, .dcx
  );

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_item(input string name, input lcd_item_t exp, input lcd_item_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_word(input string name, input axil_data_t exp, input axil_data_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_width(input string name, input wr_width_t exp, input wr_width_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %0t %s expected %0d actual %0d", $time, name, exp, act));
    end
  endtask

  task automatic check_pin(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
    end
  endtask

  // status layout: full 0, empty 1, busy 2, level 11:8
  function automatic axil_data_t status_expect(input logic is_full, input logic is_empty,
                                               input logic is_busy, input fifo_lvl_t lvl);
    axil_data_t w;
    w       = '0;
    w[0]    = is_full;
    w[1]    = is_empty;
    w[2]    = is_busy;
    w[11:8] = lvl;
    return w;
  endfunction

  // panel latches on the rising strobe
  always @(negedge wrx) begin
    fall_time = $time;
  end

  always @(posedge wrx) begin
    if (!reset) begin
      low_cycles = int'(($time - fall_time) / CLK_PERIOD);
      seen_q.push_back({dcx, lcd_data});
      if (csx !== 1'b0) begin
        fail_run("panel latched a byte while csx was high");
      end
    end
  end

  // sticky flag, queue reached its limit
  always @(negedge hwclk) begin
    if (!reset && DUT.full) begin
      saw_full = 1'b1;
    end
  end

  task automatic hold_until_reset_done();
    int n;
    n = 0;
    @(negedge hwclk);
    while (reset) begin
      n++;
      if (n > TIMEOUT_CYCLES) begin
        fail_run("reset never released");
      end
      @(negedge hwclk);
    end
  endtask

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            input int bready_delay, output axil_resp_t resp);
    int n;
    @(posedge hwclk);
    #1;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    @(negedge hwclk);
    while (!awready) begin
      n++;
      if (n > TIMEOUT_CYCLES) begin
        fail_run("timeout waiting for awready");
      end
      @(negedge hwclk);
    end
    // wready pulses together with awready
    check_pin("wready", 1'b1, wready);
    // handshake on this edge
    @(posedge hwclk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    for (int i = 0; i < bready_delay; i++) begin
      @(posedge hwclk);
      #1;
    end
    bready = 1'b1;
    n = 0;
    @(negedge hwclk);
    while (!bvalid) begin
      n++;
      if (n > TIMEOUT_CYCLES) begin
        fail_run("timeout waiting for bvalid");
      end
      @(negedge hwclk);
    end
    resp = bresp;
    @(posedge hwclk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                           output axil_resp_t resp);
    int n;
    @(posedge hwclk);
    #1;
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    @(negedge hwclk);
    while (!arready) begin
      n++;
      if (n > TIMEOUT_CYCLES) begin
        fail_run("timeout waiting for arready");
      end
      @(negedge hwclk);
    end
    @(posedge hwclk);
    #1;
    arvalid = 1'b0;
    rready  = 1'b1;
    n = 0;
    @(negedge hwclk);
    while (!rvalid) begin
      n++;
      if (n > TIMEOUT_CYCLES) begin
        fail_run("timeout waiting for rvalid");
      end
      @(negedge hwclk);
    end
    data = rdata;
    resp = rresp;
    @(posedge hwclk);
    #1;
    rready = 1'b0;
  endtask

  // one queued byte, expected on the bus later
  task automatic send_byte(input logic is_data, input lcd_byte_t b, input int delay);
    axil_resp_t resp;
    exp_q.push_back({is_data, b});
    axil_write(is_data ? REG_DATA : REG_CMD, axil_data_t'(b), delay, resp);
    check_resp("bresp", RESP_OKAY, resp);
  endtask

  task automatic wait_for_items(input int count);
    int n;
    n = 0;
    @(negedge hwclk);
    while (seen_q.size() < count) begin
      n++;
      if (n > TIMEOUT_CYCLES) begin
        fail_run("timeout waiting for bytes on the panel bus");
      end
      @(negedge hwclk);
    end
  endtask

  // csx high means the writer is back in IDLE
  task automatic drain_bus();
    int n;
    n = 0;
    @(negedge hwclk);
    while (csx !== 1'b1) begin
      n++;
      if (n > TIMEOUT_CYCLES) begin
        fail_run("timeout waiting for the panel bus to go idle");
      end
      @(negedge hwclk);
    end
  endtask

  task automatic compare_bus_log();
    check_word("bus item count", axil_data_t'(exp_q.size()), axil_data_t'(seen_q.size()));
    for (int i = 0; i < exp_q.size(); i++) begin
      check_item($sformatf("bus item %0d", i), exp_q[i], seen_q[i]);
    end
  endtask

  task automatic after_reset_defaults();
    axil_data_t rd;
    axil_resp_t resp;
    check_pin("wrx", 1'b1, wrx);
    check_pin("csx", 1'b1, csx);
    axil_read(REG_STATUS, rd, resp);
    check_resp("rresp", RESP_OKAY, resp);
    check_word("status", status_expect(1'b0, 1'b1, 1'b0, '0), rd);
    axil_read(REG_TIMING, rd, resp);
    check_resp("rresp", RESP_OKAY, resp);
    check_word("timing", 32'd2, rd);
  endtask

  task automatic cmd_data_sequence();
    seen_q.delete();
    exp_q.delete();
    send_byte(1'b0, 8'h2A, 0);
    send_byte(1'b1, 8'h11, 0);
    send_byte(1'b1, 8'h22, 0);
    send_byte(1'b1, 8'h33, 0);
    wait_for_items(4);
    compare_bus_log();
  endtask

  task automatic strobe_width_program();
    axil_data_t rd;
    axil_resp_t resp;
    seen_q.delete();
    exp_q.delete();
    axil_write(REG_TIMING, 32'd5, 0, resp);
    check_resp("bresp", RESP_OKAY, resp);
    axil_read(REG_TIMING, rd, resp);
    check_word("timing", 32'd5, rd);
    send_byte(1'b1, 8'h5A, 0);
    wait_for_items(1);
    compare_bus_log();
    check_width("wrx low cycles", wr_width_t'(5), wr_width_t'(low_cycles));
    // zero clamps to the shortest strobe
    axil_write(REG_TIMING, 32'd0, 0, resp);
    check_resp("bresp", RESP_OKAY, resp);
    axil_read(REG_TIMING, rd, resp);
    check_word("timing", 32'd1, rd);
  endtask

  task automatic queue_overrun();
    axil_resp_t resp;
    lcd_byte_t  b;
    int         d;
    seen_q.delete();
    exp_q.delete();
    saw_full = 1'b0;
    // slow strobe so the host outruns the bus
    axil_write(REG_TIMING, 32'd15, 0, resp);
    check_resp("bresp", RESP_OKAY, resp);
    for (int i = 0; i < 12; i++) begin
      b = lcd_byte_t'($urandom);
      d = int'($urandom_range(3, 0));
      send_byte(1'b1, b, d);
    end
    wait_for_items(12);
    drain_bus();
    compare_bus_log();
    check_pin("queue full seen", 1'b1, saw_full);
  endtask

  task automatic error_responses();
    axil_data_t rd;
    axil_resp_t resp;
    seen_q.delete();
    exp_q.delete();
    axil_write(4'h6, 32'h0000_00A5, 0, resp);
    check_resp("bresp", RESP_SLVERR, resp);
    axil_read(REG_CMD, rd, resp);
    check_resp("rresp", RESP_SLVERR, resp);
    check_word("rdata", 32'd0, rd);
    // quiet window, nothing may strobe
    repeat (40) @(posedge hwclk);
    #1;
    check_word("bus item count", 32'd0, axil_data_t'(seen_q.size()));
    check_pin("wrx", 1'b1, wrx);
    send_byte(1'b0, 8'h2C, 0);
    wait_for_items(1);
    compare_bus_log();
  endtask

  task automatic drain_to_idle();
    axil_data_t rd;
    axil_resp_t resp;
    drain_bus();
    axil_read(REG_STATUS, rd, resp);
    check_resp("rresp", RESP_OKAY, resp);
    check_word("status", status_expect(1'b0, 1'b1, 1'b0, '0), rd);
    check_pin("csx", 1'b1, csx);
    check_pin("wrx", 1'b1, wrx);
  endtask

  initial begin
    void'($urandom(32'h8268));
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    hold_until_reset_done();
    after_reset_defaults();
    cmd_data_sequence();
    strobe_width_program();
    queue_overrun();
    error_responses();
    drain_to_idle();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
